// File: design/trigger_pkg.sv
// single ttc_clk domain only; widths and FIFO sizes fixed here, no runtime configuration
package trigger_pkg;

    // ------------------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------------------
    localparam int NUM_CHAN    = 5;   // channel FPGAs
    localparam int TRIG_NUM_W  = 24;  // trigger and event numbers
    localparam int TIMESTAMP_W = 44;  // ttc_clk edges since reset
    localparam int DELAY_W     = 32;  // trigger delay in ttc_clk cycles
    localparam int FIFO_DEPTH  = 16;
    localparam int FIFO_AFULL  = 8;   // almost-full level, in words

    // one bit per channel
    typedef logic [NUM_CHAN-1:0] chan_mask_t;

    // as set by the TTC system, 0 is unused
    typedef enum logic [2:0] {
        TRIG_MUON_FILL = 3'd1,
        TRIG_LASER     = 3'd2,
        TRIG_PEDESTAL  = 3'd3
    } trig_type_t;

    // ------------------------------------------------------------------------
    // records
    // ------------------------------------------------------------------------
    // trigger FIFO word, 71 bits
    typedef struct packed {
        logic [TIMESTAMP_W-1:0] timestamp;
        logic [TRIG_NUM_W-1:0]  trig_num;
        trig_type_t             trig_type;
    } trig_record_t;

    // acquisition FIFO word, 32 bits
    typedef struct packed {
        logic [TRIG_NUM_W-1:0] trig_num;
        trig_type_t            trig_type;
        chan_mask_t            chan_mask;  // channels that took part
    } acq_record_t;

    // to the command manager, 95 bits
    typedef struct packed {
        logic [TRIG_NUM_W-1:0]  event_num;  // counts initiated readouts only
        logic [TRIG_NUM_W-1:0]  trig_num;
        trig_type_t             trig_type;
        logic [TIMESTAMP_W-1:0] timestamp;
    } readout_info_t;

endpackage

// File: design/sync_fifo.sv
// single clock only; m_data is valid only while m_valid is high, contents survive reset
module sync_fifo #(
    parameter type data_t = logic
) (
    input  logic  ttc_clk,
    input  logic  rst_n,
    // write side
    input  logic  s_valid,
    output logic  s_ready,
    input  data_t s_data,
    // read side
    output logic  m_valid,
    input  logic  m_ready,
    output data_t m_data,
    output logic  almost_full
);
    import trigger_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    data_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;  // occupancy
    logic             push, pop;

    assign s_ready     = (count != CNT_W'(FIFO_DEPTH));
    assign m_valid     = (count != '0);
    assign m_data      = mem[rd_ptr];  // first-word fall-through
    assign almost_full = (count >= CNT_W'(FIFO_AFULL));
    assign push        = s_valid && s_ready;
    assign pop         = m_valid && m_ready;

    always_ff @(posedge ttc_clk) begin
        if (push) mem[wr_ptr] <= s_data;
    end

    always_ff @(posedge ttc_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // wraps at the power-of-two depth
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;         // idle or one in and one out
            endcase
        end
    end

    // the reader asks only for a word that is there
    assert property (@(posedge ttc_clk) disable iff (!rst_n)
        m_ready |-> m_valid);

    // a writer turned away while full keeps its word
    assert property (@(posedge ttc_clk) disable iff (!rst_n)
        s_valid && !s_ready |=> s_valid && $stable(s_data));

endmodule

// File: design/ttc_trigger_receiver.sv
// triggers arriving while the controller is busy or the trigger FIFO is full are dropped
module ttc_trigger_receiver (
    input  logic                                 ttc_clk,
    input  logic                                 rst_n,
    input  logic                                 ttc_trigger,
    input  logic                                 rst_trigger_num,        // TTC channel B
    input  logic                                 rst_trigger_timestamp,  // TTC channel B
    input  trigger_pkg::trig_type_t              trig_type,
    // channel acquisition controller
    input  logic                                 acq_ready,
    output logic                                 acq_trigger,
    output trigger_pkg::acq_record_t             acq_rec,
    // trigger FIFO write side
    output logic                                 fifo_valid,
    input  logic                                 fifo_ready,
    output trigger_pkg::trig_record_t            fifo_data,
    // status
    output logic [trigger_pkg::TRIG_NUM_W-1:0]  trig_num,
    output logic [trigger_pkg::TIMESTAMP_W-1:0] trig_timestamp,
    output logic                                 error_trig_rate
);
    import trigger_pkg::*;

    logic [TIMESTAMP_W-1:0] ts_cnt;    // free running since reset
    logic [TRIG_NUM_W-1:0]  num_base;  // number before this cycle's increment
    logic                   accept;

    // acq_ready lags the pulse by one cycle, so acq_trigger blocks too
    assign accept   = ttc_trigger && acq_ready && fifo_ready && !acq_trigger;
    assign num_base = rst_trigger_num ? '0 : trig_num;

    // ------------------------------------------------------------------------
    // timestamp
    // ------------------------------------------------------------------------
    always_ff @(posedge ttc_clk or negedge rst_n) begin
        if (!rst_n)                     ts_cnt <= '0;
        else if (rst_trigger_timestamp) ts_cnt <= '0;
        else                            ts_cnt <= ts_cnt + 1'b1;
    end

    // ------------------------------------------------------------------------
    // accept and number
    // ------------------------------------------------------------------------
    always_ff @(posedge ttc_clk or negedge rst_n) begin
        if (!rst_n) begin
            trig_num        <= '0;
            trig_timestamp  <= '0;
            acq_trigger     <= 1'b0;
            fifo_valid      <= 1'b0;
            error_trig_rate <= 1'b0;
        end else begin
            acq_trigger <= accept;  // one-cycle pulse
            trig_num    <= accept ? num_base + 1'b1 : num_base;
            if (accept) begin
                trig_timestamp <= ts_cnt;
                fifo_valid     <= 1'b1;
            end else if (fifo_ready) begin
                fifo_valid     <= 1'b0;  // written this edge
            end
            if (ttc_trigger && !accept) error_trig_rate <= 1'b1;  // sticky
        end
    end

    // records, loaded only on accept
    always_ff @(posedge ttc_clk) begin
        if (accept) begin
            fifo_data <= '{timestamp: ts_cnt, trig_num: num_base + 1'b1,
                           trig_type: trig_type};
            acq_rec   <= '{trig_num: num_base + 1'b1, trig_type: trig_type,
                           chan_mask: '0};  // mask is the controller's job
        end
    end

    // controller must still be idle when the pulse reaches it
    assert property (@(posedge ttc_clk) disable iff (!rst_n)
        acq_trigger |-> acq_ready);

endmodule

// File: design/channel_acq_controller.sv
// one trigger in flight at a time; a channel that never reports done stalls the path
module channel_acq_controller (
    input  logic                              ttc_clk,
    input  logic                              rst_n,
    input  trigger_pkg::chan_mask_t           chan_en,
    input  logic [trigger_pkg::DELAY_W-1:0]  trig_delay,  // ttc_clk cycles
    // from the trigger receiver
    input  logic                              acq_trigger,
    input  trigger_pkg::acq_record_t          acq_rec_in,
    output logic                              acq_ready,
    // channel FPGAs
    input  trigger_pkg::chan_mask_t           chan_dones,
    output trigger_pkg::chan_mask_t           chan_enable,
    output trigger_pkg::chan_mask_t           chan_trig,
    // acquisition FIFO write side
    output logic                              fifo_valid,
    input  logic                              fifo_ready,
    output trigger_pkg::acq_record_t          fifo_data
);
    import trigger_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_DELAY,       // counting down trig_delay
        S_WAIT_DONES,  // collecting done pulses
        S_QUEUE        // record offered to the FIFO
    } state_t;

    state_t             state;
    logic [DELAY_W-1:0] delay_cnt;
    chan_mask_t         mask;      // chan_en captured with the trigger
    chan_mask_t         done_acc;  // dones seen so far
    chan_mask_t         done_now;

    assign done_now    = done_acc | chan_dones;
    assign acq_ready   = (state == S_IDLE);
    assign chan_enable = (state == S_IDLE) ? '0 : mask;  // held until queued

    // ------------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge ttc_clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            delay_cnt  <= '0;
            done_acc   <= '0;
            chan_trig  <= '0;
            fifo_valid <= 1'b0;
        end else begin
            chan_trig <= '0;  // pulse by default
            case (state)
                S_IDLE: if (acq_trigger) begin
                    delay_cnt <= trig_delay;
                    done_acc  <= '0;
                    if (chan_en == '0) begin  // nobody to trigger so queue at once
                        state      <= S_QUEUE;
                        fifo_valid <= 1'b1;
                    end else begin
                        state <= S_DELAY;
                    end
                end
                S_DELAY: begin
                    if (delay_cnt == '0) begin  // trig_delay+1 edges after capture
                        chan_trig <= mask;
                        state     <= S_WAIT_DONES;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                S_WAIT_DONES: begin
                    done_acc <= done_now;
                    if ((done_now & mask) == mask) begin  // every enabled channel in
                        state      <= S_QUEUE;
                        fifo_valid <= 1'b1;
                    end
                end
                S_QUEUE: if (fifo_ready) begin  // back-pressure keeps us here
                    fifo_valid <= 1'b0;
                    state      <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // trigger record captured with the trigger
    always_ff @(posedge ttc_clk) begin
        if (state == S_IDLE && acq_trigger) begin
            mask      <= chan_en;
            fifo_data <= '{trig_num: acq_rec_in.trig_num, trig_type: acq_rec_in.trig_type,
                           chan_mask: chan_en};
        end
    end

    // done pulses come only from enabled channels
    assert property (@(posedge ttc_clk) disable iff (!rst_n)
        (chan_dones & ~chan_enable) == '0);

endmodule

// File: design/trigger_processor.sv
// readout_info is meaningful only with initiate_readout or send_empty_event
module trigger_processor (
    input  logic                         ttc_clk,
    input  logic                         rst_n,
    // trigger FIFO read side
    input  logic                         trig_valid,
    output logic                         trig_ready,
    input  trigger_pkg::trig_record_t    trig_data,
    // acquisition FIFO read side
    input  logic                         acq_valid,
    output logic                         acq_ready,
    input  trigger_pkg::acq_record_t     acq_data,
    input  logic                         rst_trigger_num,  // also restarts event_num
    // command manager
    input  logic                         readout_ready,    // high while the manager is idle
    input  logic                         readout_done,     // pulse
    output logic                         initiate_readout,
    output logic                         send_empty_event,
    output trigger_pkg::readout_info_t   readout_info,
    // sticky errors
    output logic                         error_trig_num,
    output logic                         error_trig_type
);
    import trigger_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_DECIDE,    // pick readout or empty event for the popped pair
        S_WAIT_DONE  // readout running
    } state_t;

    state_t                state;
    logic                  pop;
    logic [TRIG_NUM_W-1:0] event_cnt;
    logic [TRIG_NUM_W-1:0] event_base;
    trig_record_t          trig_q;
    chan_mask_t            mask_q;

    // both FIFOs pop together
    assign pop        = (state == S_IDLE) && trig_valid && acq_valid && readout_ready;
    assign trig_ready = pop;
    assign acq_ready  = pop;
    assign event_base = rst_trigger_num ? '0 : event_cnt;

    always_ff @(posedge ttc_clk or negedge rst_n) begin
        if (!rst_n) begin
            state            <= S_IDLE;
            event_cnt        <= '0;
            initiate_readout <= 1'b0;
            send_empty_event <= 1'b0;
            error_trig_num   <= 1'b0;
            error_trig_type  <= 1'b0;
        end else begin
            initiate_readout <= 1'b0;
            send_empty_event <= 1'b0;
            event_cnt        <= event_base;
            case (state)
                S_IDLE: if (pop) begin
                    state <= S_DECIDE;
                    // records out of step between the FIFOs
                    if (trig_data.trig_num != acq_data.trig_num)   error_trig_num  <= 1'b1;
                    if (trig_data.trig_type != acq_data.trig_type) error_trig_type <= 1'b1;
                end
                S_DECIDE: begin
                    if (mask_q == '0) begin
                        send_empty_event <= 1'b1;
                        state            <= S_IDLE;  // nothing to wait for
                    end else begin
                        initiate_readout <= 1'b1;
                        event_cnt        <= event_base + 1'b1;
                        state            <= S_WAIT_DONE;
                    end
                end
                S_WAIT_DONE: if (readout_done) state <= S_IDLE;
                default:     state <= S_IDLE;
            endcase
        end
    end

    // popped records and outgoing info
    always_ff @(posedge ttc_clk) begin
        if (pop) begin
            trig_q <= trig_data;
            mask_q <= acq_data.chan_mask;
        end
        if (state == S_DECIDE) begin
            readout_info <= '{event_num: (mask_q == '0) ? event_base : event_base + 1'b1,
                              trig_num:  trig_q.trig_num,
                              trig_type: trig_q.trig_type,
                              timestamp: trig_q.timestamp};
        end
    end

    // the command manager reports done only for a readout in progress
    assert property (@(posedge ttc_clk) disable iff (!rst_n)
        readout_done |-> (state == S_WAIT_DONE));

endmodule

// File: design/trigger_top.sv
// single ttc_clk domain; chan_dones and readout_done must already be synchronous pulses
module trigger_top (
    input  logic                                 ttc_clk,
    input  logic                                 rst_n,
    input  logic                                 ttc_trigger,
    input  logic                                 rst_trigger_num,        // TTC channel B
    input  logic                                 rst_trigger_timestamp,  // TTC channel B
    input  trigger_pkg::trig_type_t              trig_type,
    input  trigger_pkg::chan_mask_t              chan_en,
    input  logic [trigger_pkg::DELAY_W-1:0]     trig_delay,
    // channel FPGAs
    input  trigger_pkg::chan_mask_t              chan_dones,
    output trigger_pkg::chan_mask_t              chan_enable,
    output trigger_pkg::chan_mask_t              chan_trig,
    // command manager
    input  logic                                 readout_ready,
    input  logic                                 readout_done,
    output logic                                 initiate_readout,
    output logic                                 send_empty_event,
    output trigger_pkg::readout_info_t           readout_info,
    // status and errors
    output logic [trigger_pkg::TRIG_NUM_W-1:0]  trig_num,
    output logic [trigger_pkg::TIMESTAMP_W-1:0] trig_timestamp,
    output logic                                 trig_fifo_full,   // almost full
    output logic                                 acq_fifo_full,    // almost full
    output logic                                 error_trig_rate,
    output logic                                 error_trig_num,
    output logic                                 error_trig_type
);
    import trigger_pkg::*;

    // ------------------------------------------------------------------------
    // receiver to controller, and the two FIFO ports
    // ------------------------------------------------------------------------
    logic         acq_ready, acq_trigger;
    acq_record_t  acq_rec;
    logic         trig_s_valid, trig_s_ready, trig_m_valid, trig_m_ready;
    trig_record_t trig_s_data, trig_m_data;
    logic         acq_s_valid, acq_s_ready, acq_m_valid, acq_m_ready;
    acq_record_t  acq_s_data, acq_m_data;

    ttc_trigger_receiver u_receiver (
        .ttc_clk, .rst_n, .ttc_trigger, .rst_trigger_num, .rst_trigger_timestamp,
        .trig_type, .acq_ready, .acq_trigger, .acq_rec,
        .fifo_valid(trig_s_valid), .fifo_ready(trig_s_ready), .fifo_data(trig_s_data),
        .trig_num, .trig_timestamp, .error_trig_rate
    );

    channel_acq_controller u_controller (
        .ttc_clk, .rst_n, .chan_en, .trig_delay, .acq_trigger,
        .acq_rec_in(acq_rec), .acq_ready, .chan_dones, .chan_enable, .chan_trig,
        .fifo_valid(acq_s_valid), .fifo_ready(acq_s_ready), .fifo_data(acq_s_data)
    );

    sync_fifo #(.data_t(trig_record_t)) trig_fifo (
        .ttc_clk, .rst_n, .s_valid(trig_s_valid), .s_ready(trig_s_ready),
        .s_data(trig_s_data), .m_valid(trig_m_valid), .m_ready(trig_m_ready),
        .m_data(trig_m_data), .almost_full(trig_fifo_full)
    );

    sync_fifo #(.data_t(acq_record_t)) acq_fifo (
        .ttc_clk, .rst_n, .s_valid(acq_s_valid), .s_ready(acq_s_ready),
        .s_data(acq_s_data), .m_valid(acq_m_valid), .m_ready(acq_m_ready),
        .m_data(acq_m_data), .almost_full(acq_fifo_full)
    );

    trigger_processor u_processor (
        .ttc_clk, .rst_n,
        .trig_valid(trig_m_valid), .trig_ready(trig_m_ready), .trig_data(trig_m_data),
        .acq_valid(acq_m_valid), .acq_ready(acq_m_ready), .acq_data(acq_m_data),
        .rst_trigger_num, .readout_ready, .readout_done, .initiate_readout,
        .send_empty_event, .readout_info, .error_trig_num, .error_trig_type
    );

endmodule

// File: test/tb_clock_gen.sv
// free-running 10 ns clock; rst_n released 1 ns after the last reset edge, never asserted again
module tb_clock_gen #(
    parameter int RESET_CYCLES = 16
) (
    output logic ttc_clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial ttc_clk = 1'b0;
    always #5 ttc_clk = ~ttc_clk;  // 10 ns period

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge ttc_clk);
        #1 rst_n = 1'b1;  // off the edge
    end

endmodule

// File: test/trigger_top_tb.sv
// one trigger in flight per stimulus line; rst_trigger_timestamp is held low for the whole run
module trigger_top_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import trigger_pkg::*;

    localparam int NUM_LINES    = 14;
    localparam int NUM_COLS     = 9;   // columns per stimulus line
    localparam int RESET_CYCLES = 16;

    logic                   ttc_clk, rst_n;
    logic                   ttc_trigger, rst_trigger_num, rst_trigger_timestamp;
    trig_type_t             trig_type;
    chan_mask_t             chan_en, chan_dones, chan_enable, chan_trig;
    logic [DELAY_W-1:0]     trig_delay;
    logic                   readout_ready, readout_done, initiate_readout, send_empty_event;
    readout_info_t          readout_info;
    logic [TRIG_NUM_W-1:0]  trig_num;
    logic [TIMESTAMP_W-1:0] trig_timestamp;
    logic                   trig_fifo_full, acq_fifo_full;
    logic                   error_trig_rate, error_trig_num, error_trig_type;

    logic [31:0]     stim [NUM_LINES*NUM_COLS];
    longint unsigned edge_cnt = 0;        // edges since reset release
    logic            rate_err_exp = 1'b0;  // sticky like the DUT flag

    tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) clock_gen (.ttc_clk, .rst_n);

    trigger_top UUT (.*);

    always @(posedge ttc_clk) begin
        if (rst_n) edge_cnt <= edge_cnt + 1;
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    task automatic next_cycle();  // drive and sample point 1 ns past the edge
        @(posedge ttc_clk);
        #1;
    endtask

    task automatic expect_equal(input string name, input logic [127:0] got, exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Something failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic watchdog(input int unsigned limit);
        repeat (limit) @(posedge ttc_clk);
        $display("Something failed");
        $fatal(1, "run timed out after %0d clock cycles without finishing", limit);
    endtask

    // each channel answers its chan_trig bit with one done pulse after a random wait
    task automatic respond_dones();
        int unsigned wait_left [NUM_CHAN];
        chan_mask_t  pulse;
        forever begin
            next_cycle();
            pulse = '0;
            for (int i = 0; i < NUM_CHAN; i++) begin
                if (chan_trig[i]) begin
                    wait_left[i] = $urandom_range(12, 1);
                end else if (wait_left[i] != 0) begin
                    wait_left[i]--;
                    pulse[i] = (wait_left[i] == 0);
                end
            end
            chan_dones = pulse;
        end
    endtask

    // ------------------------------------------------------------------------
    // one trigger per stimulus line
    // ------------------------------------------------------------------------
    task automatic run_line(input int n);
        int unsigned           base, delay, gap, ready_low, lat, waited;
        trig_type_t            ty;
        chan_mask_t            mask;
        logic                  second, rst_num;
        logic [TRIG_NUM_W-1:0] exp_trig, exp_event;
        longint unsigned       exp_ts;
        base      = n * NUM_COLS;
        ty        = trig_type_t'(stim[base][2:0]);
        mask      = chan_mask_t'(stim[base+1]);
        delay     = stim[base+2];
        gap       = stim[base+3];
        ready_low = stim[base+4];
        second    = stim[base+5][0];
        rst_num   = stim[base+6][0];
        exp_trig  = TRIG_NUM_W'(stim[base+7]);
        exp_event = TRIG_NUM_W'(stim[base+8]);
        repeat (gap) next_cycle();
        if (rst_num) begin
            rst_trigger_num = 1'b1;  // restarts trig_num and event_num
            next_cycle();
            rst_trigger_num = 1'b0;
        end
        trig_type     = ty;
        chan_en       = mask;
        trig_delay    = delay;
        readout_ready = (ready_low == 0);
        ttc_trigger   = 1'b1;
        exp_ts        = edge_cnt;  // counter value at the sampling edge
        fork
            begin  // trigger pulse and maybe a second one while busy
                next_cycle();
                ttc_trigger = 1'b0;
                expect_equal("trig_num", trig_num, exp_trig);
                expect_equal("trig_timestamp", trig_timestamp, exp_ts);
                if (second) begin
                    next_cycle();
                    ttc_trigger = 1'b1;
                    next_cycle();
                    ttc_trigger = 1'b0;
                end
            end
            if (mask != '0) begin  // chan_trig timing with lat counting edges from the trigger
                lat = 0;
                next_cycle();
                while (chan_trig == '0 && lat <= delay + 2) begin
                    if (lat >= 1) expect_equal("chan_enable", chan_enable, mask);
                    next_cycle();
                    lat++;
                end
                expect_equal("chan_trig latency", lat, delay + 2);
                expect_equal("chan_trig", chan_trig, mask);
                while (chan_enable != '0) begin  // held through the done collection
                    expect_equal("chan_enable", chan_enable, mask);
                    next_cycle();
                end
            end
            begin
                repeat (ready_low) next_cycle();
                readout_ready = 1'b1;
            end
            begin  // command manager side
                waited = 0;
                do begin
                    next_cycle();
                    waited++;
                    if (mask == '0) expect_equal("chan_trig", chan_trig, '0);
                    expect_equal("trig_fifo_full", trig_fifo_full, 1'b0);  // one word at most
                    expect_equal("acq_fifo_full", acq_fifo_full, 1'b0);
                end while (!initiate_readout && !send_empty_event);
                expect_equal("initiate_readout", initiate_readout, mask != '0);
                expect_equal("send_empty_event", send_empty_event, mask == '0);
                expect_equal("readout held by readout_ready", waited > ready_low, 1'b1);
                expect_equal("readout_info.trig_num", readout_info.trig_num, exp_trig);
                expect_equal("readout_info.trig_type", readout_info.trig_type, ty);
                expect_equal("readout_info.timestamp", readout_info.timestamp, exp_ts);
                expect_equal("readout_info.event_num", readout_info.event_num, exp_event);
                expect_equal("chan_enable", chan_enable, '0);  // record already queued
                if (initiate_readout) begin
                    repeat ($urandom_range(10, 1)) next_cycle();
                    readout_done = 1'b1;
                    next_cycle();
                    readout_done = 1'b0;
                end
            end
        join
        if (second) rate_err_exp = 1'b1;
        expect_equal("error_trig_rate", error_trig_rate, rate_err_exp);
        expect_equal("trig_num", trig_num, exp_trig);  // rejected one took no number
        expect_equal("error_trig_num", error_trig_num, 1'b0);
        expect_equal("error_trig_type", error_trig_type, 1'b0);
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        int unsigned max_delay, max_gap, limit;
        ttc_trigger           = 1'b0;
        rst_trigger_num       = 1'b0;
        rst_trigger_timestamp = 1'b0;
        trig_type             = TRIG_MUON_FILL;
        chan_en               = '0;
        trig_delay            = '0;
        chan_dones            = '0;
        readout_ready         = 1'b1;
        readout_done          = 1'b0;
        void'($urandom(32'h9bec969d));  // forked children inherit this seed
        $readmemh("test/trigger_stimulus.txt", stim);
        if ($isunknown(stim[NUM_LINES*NUM_COLS-1])) begin
            $display("Something failed");
            $fatal(1, "stimulus file missing or shorter than %0d lines", NUM_LINES);
        end
        max_delay = 0;
        max_gap   = 0;
        for (int n = 0; n < NUM_LINES; n++) begin
            if (stim[n*NUM_COLS+2] > max_delay) max_delay = stim[n*NUM_COLS+2];
            if (stim[n*NUM_COLS+3] > max_gap) max_gap = stim[n*NUM_COLS+3];
        end
        limit = RESET_CYCLES + NUM_LINES * (max_delay + max_gap + 200);
        fork
            watchdog(limit);
            respond_dones();
        join_none
        @(posedge rst_n);
        next_cycle();
        for (int n = 0; n < NUM_LINES; n++) run_line(n);
        $display("Everything OK");
        $finish;
    end

endmodule

// File: test/trigger_stimulus.txt
// type chan_en trig_delay gap ready_low second_trig rst_num exp_trig_num exp_event_num
// all hex; type 1 muon fill, 2 laser, 3 pedestal; chan_en 00 gives an empty event
1 1f 03 05 00 0 0 01 01
2 00 00 02 00 0 0 02 01
1 05 00 00 00 0 0 03 02
3 0a 14 08 00 1 0 04 03
1 1f 02 03 1e 0 0 05 04
2 00 05 04 10 1 0 06 04
1 10 07 00 00 0 1 01 01
1 03 01 06 04 0 0 02 02
3 00 00 01 00 0 1 01 00
2 1f 28 02 00 0 0 02 01
1 01 00 00 05 1 0 03 02
3 1e 04 09 00 0 0 04 03
2 00 00 00 0c 0 0 05 03
1 1f 00 03 00 0 0 06 04

// File: verilog.f
design/trigger_pkg.sv
design/sync_fifo.sv
design/ttc_trigger_receiver.sv
design/channel_acq_controller.sv
design/trigger_processor.sv
design/trigger_top.sv
test/tb_clock_gen.sv
test/trigger_top_tb.sv

// File: Bender.yml
package:
  name: trigger_path

sources:
  - design/trigger_pkg.sv
  - design/sync_fifo.sv
  - design/ttc_trigger_receiver.sv
  - design/channel_acq_controller.sv
  - design/trigger_processor.sv
  - design/trigger_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/trigger_top_tb.sv
